// ==== logic/mem_pkg.sv ====
package mem_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  gpr_idx_t;
    typedef logic [4:0]  cache_op_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [2:0]  fwd_sel_t;     // one-hot, all zero gives a zero operand

    // delayed alu operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10
    } alu_op_e;

    // operand source bits in fwd_sel_t
    localparam int FWD_ID    = 0;
    localparam int FWD_REEXE = 1;
    localparam int FWD_WB    = 2;

    // cache target, low two opcode bits
    localparam logic [1:0] CACHE_TGT_ICACHE = 2'b00;
    localparam logic [1:0] CACHE_TGT_DCACHE = 2'b01;

    localparam exc_code_t EXC_INT = 5'd0;

    // cp0 field positions
    localparam int CP0_IP_LSB     = 8;  // cause ip and status im share this layout
    localparam int CP0_STATUS_EXL = 1;

    ////////////////////////////////////////////////////////////
    // instruction bundle held by the stage register
    typedef struct packed {
        gpr_idx_t          write_num;
        word_t             pc;
        logic              is_delay_slot;
        word_t             pre_res;
        logic              has_exc;
        exc_code_t         exc_code;
        word_t             bad_vaddr;
        logic              read_cp0;
        logic              is_cache;
        cache_op_t         cache_op;
        logic              not_exc;     // alu op runs in this stage
        logic [1:0]        src_is_reg;
        fwd_sel_t [1:0]    fwd_sel;
        word_t [1:0]       imm_src;
        word_t [1:0]       id_data;
        word_t             reexe_data;
        alu_op_e           alu_op;
    } mem_inst_t;

endpackage

// ==== logic/stage_bus_if.sv ====
`timescale 1ns/1ps

interface stage_bus_if import mem_pkg::*; (input logic clk);

    mem_inst_t inst;        // latched bundle
    logic      has_data;    // stage occupied
    logic      update;      // new instruction at next edge
    logic      clear;       // stage empties at next edge

    // latch side, strobes are forwarded from the commit logic
    modport latch (
        output inst, has_data, update, clear
    );

    modport user (
        input clk, inst, has_data, update, clear
    );

endinterface

// ==== logic/stage_latch.sv ====
`timescale 1ns/1ps

module stage_latch import mem_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       update_i,
    input  logic       clear_i,
    input  mem_inst_t  inst_i,
    stage_bus_if.latch bus_o
);

    mem_inst_t inst_q;
    logic      has_data_q;

    ////////////////////////////////////////////////////////////
    // occupancy
    // update only comes with an upstream valid, so a load means occupied
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            has_data_q <= 1'b0;
        end else if (clear_i) begin
            has_data_q <= 1'b0;
        end else if (update_i) begin
            has_data_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction bundle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_q <= '0;
        end else if (clear_i) begin
            inst_q <= '0;           // flush or bubble
        end else if (update_i) begin
            inst_q <= inst_i;
        end
        // otherwise hold, back-pressure or waiting on cache
    end

    assign bus_o.inst     = inst_q;
    assign bus_o.has_data = has_data_q;

    // strobes go out on the bus for the forwarding copy in the exec unit
    assign bus_o.update   = update_i;
    assign bus_o.clear    = clear_i;

endmodule

// ==== logic/delayed_exec.sv ====
`timescale 1ns/1ps

module delayed_exec import mem_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    stage_bus_if.user bus_i,
    input  word_t     wb_fwd_i,
    output word_t     exec_res_o
);

    word_t src [2];     // final alu operands

    ////////////////////////////////////////////////////////////
    // operand select with frozen write-back copy
    for (genvar i = 0; i < 2; i++) begin : g_opnd
        fwd_sel_t fsel;
        logic     use_saved;
        word_t    wb_saved;
        word_t    wb_data;
        word_t    reg_data;

        assign fsel = bus_i.inst.fwd_sel[i];

        // set after the first cycle of stay, dropped when the stage changes
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                use_saved <= 1'b0;
            end else if (bus_i.update || bus_i.clear) begin
                use_saved <= 1'b0;
            end else if (bus_i.has_data && fsel[FWD_WB]) begin
                use_saved <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (fsel[FWD_WB] && !use_saved) begin
                wb_saved <= wb_fwd_i;   // write-back moves on, keep what we saw
            end
        end

        assign wb_data  = use_saved ? wb_saved : wb_fwd_i;

        assign reg_data = ({32{fsel[FWD_ID]}}    & bus_i.inst.id_data[i])
                        | ({32{fsel[FWD_REEXE]}} & bus_i.inst.reexe_data)
                        | ({32{fsel[FWD_WB]}}    & wb_data);

        assign src[i] = bus_i.inst.src_is_reg[i] ? reg_data : bus_i.inst.imm_src[i];
    end

    ////////////////////////////////////////////////////////////
    // alu, no overflow reporting
    always_comb begin
        case (bus_i.inst.alu_op)
            ALU_ADD:  exec_res_o = src[0] + src[1];
            ALU_SUB:  exec_res_o = src[0] - src[1];
            ALU_AND:  exec_res_o = src[0] & src[1];
            ALU_OR:   exec_res_o = src[0] | src[1];
            ALU_XOR:  exec_res_o = src[0] ^ src[1];
            ALU_NOR:  exec_res_o = ~(src[0] | src[1]);
            // shift amount from operand 0
            ALU_SLL:  exec_res_o = src[1] << src[0][4:0];
            ALU_SRL:  exec_res_o = src[1] >> src[0][4:0];
            ALU_SRA:  exec_res_o = word_t'($signed(src[1]) >>> src[0][4:0]);
            ALU_SLT:  exec_res_o = {31'b0, $signed(src[0]) < $signed(src[1])};
            ALU_SLTU: exec_res_o = {31'b0, src[0] < src[1]};
            default:  exec_res_o = '0;
        endcase
    end

endmodule

// ==== logic/cache_dispatch.sv ====
`timescale 1ns/1ps

module cache_dispatch import mem_pkg::*; (
    stage_bus_if.user bus_i,
    input  logic      issue_en_i,
    input  logic      icache_ok_i,
    input  logic      dcache_ok_i,
    output logic      icache_req_o,
    output logic      dcache_req_o,
    output cache_op_t icache_op_o,
    output cache_op_t dcache_op_o,
    output word_t     icache_addr_o,
    output word_t     dcache_addr_o,
    output logic      cache_busy_o,
    output logic      cache_done_o,
    output logic      is_cache_o
);

    logic to_icache;
    logic to_dcache;

    assign is_cache_o = bus_i.has_data && bus_i.inst.is_cache;

    // target from the low opcode bits
    assign to_icache = bus_i.inst.cache_op[1:0] == CACHE_TGT_ICACHE;
    assign to_dcache = bus_i.inst.cache_op[1:0] == CACHE_TGT_DCACHE;

    assign icache_req_o = is_cache_o && to_icache && issue_en_i;
    assign dcache_req_o = is_cache_o && to_dcache && issue_en_i;

    assign icache_op_o   = bus_i.inst.cache_op;
    assign dcache_op_o   = bus_i.inst.cache_op;
    assign icache_addr_o = bus_i.inst.pre_res;     // address computed upstream
    assign dcache_addr_o = bus_i.inst.pre_res;

    // waiting on ok / finished this cycle
    assign cache_busy_o = (icache_req_o && !icache_ok_i) || (dcache_req_o && !dcache_ok_i);
    assign cache_done_o = (icache_req_o && icache_ok_i) || (dcache_req_o && dcache_ok_i);

endmodule

// ==== logic/stage_commit.sv ====
`timescale 1ns/1ps

module stage_commit import mem_pkg::*; #(
    parameter int unsigned NUM_IRQ = 8
) (
    stage_bus_if.user bus_i,
    input  logic      prev_valid_i,
    input  logic      next_allowin_i,
    input  logic      reexe_ok_i,
    input  logic      flush_i,
    input  logic      wb_has_risk_i,
    input  word_t     cause_i,
    input  word_t     status_i,
    input  word_t     cp0_rdata_i,
    input  word_t     exec_res_i,
    input  logic      cache_busy_i,
    input  logic      cache_done_i,
    input  logic      is_cache_i,
    input  mem_inst_t inst_i,
    output logic      update_o,
    output logic      clear_o,
    output logic      issue_en_o,
    output logic      allowin_o,
    output logic      valid_o,
    output word_t     final_res_o,
    output logic      has_exception_o,
    output logic      is_interrupt_o,
    output exc_code_t exc_code_o,
    output word_t     except_pc_o,
    output word_t     bad_vaddr_o,
    output logic      is_delay_slot_o,
    output logic      cache_flush_o
);

    logic irq_pend;
    logic has_int;
    logic cache_risk;
    logic ready;

    ////////////////////////////////////////////////////////////
    // interrupt and exception
    assign irq_pend = |(cause_i[CP0_IP_LSB +: NUM_IRQ] & status_i[CP0_IP_LSB +: NUM_IRQ]);
    assign has_int  = irq_pend && !status_i[CP0_STATUS_EXL] && bus_i.has_data;

    assign is_interrupt_o  = has_int;
    assign has_exception_o = has_int || (bus_i.has_data && inst_i.has_exc);
    assign exc_code_o      = has_int ? EXC_INT : inst_i.exc_code;   // interrupt wins
    assign except_pc_o     = inst_i.pc;
    assign bad_vaddr_o     = inst_i.bad_vaddr;
    assign is_delay_slot_o = inst_i.is_delay_slot;

    // no cache op while something older may still trap
    assign issue_en_o = !has_exception_o && !wb_has_risk_i;

    ////////////////////////////////////////////////////////////
    // pipeline interlock
    assign cache_risk = is_cache_i && wb_has_risk_i;
    assign ready      = !(cache_busy_i || cache_risk);

    assign allowin_o = reexe_ok_i && next_allowin_i && (ready || !bus_i.has_data);
    assign valid_o   = bus_i.has_data && ready && allowin_o && !flush_i;

    assign update_o = allowin_o && prev_valid_i;
    assign clear_o  = (allowin_o && !prev_valid_i) || flush_i;  // bubble or flush

    assign cache_flush_o = cache_done_i;

    // final result
    assign final_res_o = inst_i.read_cp0 ? cp0_rdata_i
                       : inst_i.not_exc  ? exec_res_i
                       : inst_i.pre_res;

endmodule

// ==== logic/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top import mem_pkg::*; #(
    parameter int unsigned NUM_IRQ = 8
) (
    input  logic           clk,
    input  logic           arst_n_i,
    // upstream bundle
    input  gpr_idx_t       write_num_i,
    input  word_t          pc_i,
    input  logic           is_delay_slot_i,
    input  word_t          pre_res_i,
    input  logic           has_exc_i,
    input  exc_code_t      exc_code_i,
    input  word_t          bad_vaddr_i,
    input  logic           read_cp0_i,
    input  logic           is_cache_i,
    input  cache_op_t      cache_op_i,
    input  logic           not_exc_i,
    input  logic [1:0]     src_is_reg_i,
    input  fwd_sel_t [1:0] fwd_sel_i,
    input  word_t [1:0]    imm_src_i,
    input  word_t [1:0]    id_data_i,
    input  word_t          reexe_data_i,
    input  alu_op_e        alu_op_i,
    // interlock and context
    input  logic           prev_valid_i,
    input  logic           next_allowin_i,
    input  logic           reexe_ok_i,
    input  logic           flush_i,
    input  logic           wb_has_risk_i,
    input  word_t          cause_i,
    input  word_t          status_i,
    input  word_t          cp0_rdata_i,
    input  word_t          wb_fwd_i,
    // cache ports
    input  logic           icache_ok_i,
    input  logic           dcache_ok_i,
    output logic           icache_req_o,
    output logic           dcache_req_o,
    output cache_op_t      icache_op_o,
    output cache_op_t      dcache_op_o,
    output word_t          icache_addr_o,
    output word_t          dcache_addr_o,
    // results
    output logic           allowin_o,
    output logic           valid_o,
    output gpr_idx_t       write_num_o,
    output word_t          final_res_o,
    output logic           has_exception_o,
    output logic           is_interrupt_o,
    output exc_code_t      exc_code_o,
    output word_t          except_pc_o,
    output word_t          bad_vaddr_o,
    output logic           is_delay_slot_o,
    output logic           cache_flush_o
);

    mem_inst_t in_inst;
    word_t     exec_res;
    logic      update, clear, issue_en;
    logic      cache_busy, cache_done, is_cache;

    stage_bus_if u_bus (.clk(clk));

    assign in_inst = '{
        write_num:     write_num_i,
        pc:            pc_i,
        is_delay_slot: is_delay_slot_i,
        pre_res:       pre_res_i,
        has_exc:       has_exc_i,
        exc_code:      exc_code_i,
        bad_vaddr:     bad_vaddr_i,
        read_cp0:      read_cp0_i,
        is_cache:      is_cache_i,
        cache_op:      cache_op_i,
        not_exc:       not_exc_i,
        src_is_reg:    src_is_reg_i,
        fwd_sel:       fwd_sel_i,
        imm_src:       imm_src_i,
        id_data:       id_data_i,
        reexe_data:    reexe_data_i,
        alu_op:        alu_op_i
    };

    assign write_num_o = u_bus.inst.write_num;

    ////////////////////////////////////////////////////////////
    stage_latch u_latch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .update_i (update),
        .clear_i  (clear),
        .inst_i   (in_inst),
        .bus_o    (u_bus.latch)
    );

    delayed_exec u_exec (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus_i      (u_bus.user),
        .wb_fwd_i   (wb_fwd_i),
        .exec_res_o (exec_res)
    );

    cache_dispatch u_cache (
        .bus_i         (u_bus.user),
        .issue_en_i    (issue_en),
        .icache_ok_i   (icache_ok_i),
        .dcache_ok_i   (dcache_ok_i),
        .icache_req_o  (icache_req_o),
        .dcache_req_o  (dcache_req_o),
        .icache_op_o   (icache_op_o),
        .dcache_op_o   (dcache_op_o),
        .icache_addr_o (icache_addr_o),
        .dcache_addr_o (dcache_addr_o),
        .cache_busy_o  (cache_busy),
        .cache_done_o  (cache_done),
        .is_cache_o    (is_cache)
    );

    stage_commit #(
        .NUM_IRQ (NUM_IRQ)
    ) u_commit (
        .bus_i           (u_bus.user),
        .prev_valid_i    (prev_valid_i),
        .next_allowin_i  (next_allowin_i),
        .reexe_ok_i      (reexe_ok_i),
        .flush_i         (flush_i),
        .wb_has_risk_i   (wb_has_risk_i),
        .cause_i         (cause_i),
        .status_i        (status_i),
        .cp0_rdata_i     (cp0_rdata_i),
        .exec_res_i      (exec_res),
        .cache_busy_i    (cache_busy),
        .cache_done_i    (cache_done),
        .is_cache_i      (is_cache),
        .inst_i          (u_bus.inst),
        .update_o        (update),
        .clear_o         (clear),
        .issue_en_o      (issue_en),
        .allowin_o       (allowin_o),
        .valid_o         (valid_o),
        .final_res_o     (final_res_o),
        .has_exception_o (has_exception_o),
        .is_interrupt_o  (is_interrupt_o),
        .exc_code_o      (exc_code_o),
        .except_pc_o     (except_pc_o),
        .bad_vaddr_o     (bad_vaddr_o),
        .is_delay_slot_o (is_delay_slot_o),
        .cache_flush_o   (cache_flush_o)
    );

endmodule

// ==== test/mem_stage_assertions.sv ====
`timescale 1ns/1ps

module mem_stage_assertions import mem_pkg::*; (
    input logic      clk,
    input logic      has_data_i,
    input logic      valid_i,
    input logic      flush_i,
    input logic      next_allowin_i,
    input logic      clear_i,
    input logic      is_cache_i,
    input logic      cache_done_i,
    input logic      has_exception_i,
    input mem_inst_t inst_i
);

    // nothing leaves an empty stage
    a_valid_needs_data: assert property (@(posedge clk) valid_i |-> has_data_i)
        else $error("valid_o high while the stage is empty");

    a_no_cache_when_empty: assert property (@(posedge clk)
        !has_data_i |-> !is_cache_i && !cache_done_i)
        else $error("cache activity while the stage is empty");

    // back-pressure keeps the held instruction as it is
    a_hold_under_stall: assert property (@(posedge clk)
        has_data_i && !next_allowin_i && !flush_i |=> has_data_i && $stable(inst_i))
        else $error("stage contents changed while stalled");

    a_clear_empties: assert property (@(posedge clk) clear_i |=> !has_data_i)
        else $error("stage still occupied after clear");

    // a cache op only retires together with its ok
    a_cache_retire: assert property (@(posedge clk)
        valid_i && is_cache_i && !has_exception_i |-> cache_done_i)
        else $error("cache instruction retired without acknowledge");

endmodule

bind stage_commit mem_stage_assertions u_assertions (
    .clk             (bus_i.clk),
    .has_data_i      (bus_i.has_data),
    .valid_i         (valid_o),
    .flush_i         (flush_i),
    .next_allowin_i  (next_allowin_i),
    .clear_i         (clear_o),
    .is_cache_i      (is_cache_i),
    .cache_done_i    (cache_done_i),
    .has_exception_i (has_exception_o),
    .inst_i          (inst_i)
);

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NCOL       = 24;

    logic clk, arst_n_i;
    gpr_idx_t write_num_i, write_num_o;
    word_t pc_i, pre_res_i, bad_vaddr_i, reexe_data_i, cause_i, status_i, cp0_rdata_i, wb_fwd_i;
    logic is_delay_slot_i, has_exc_i, read_cp0_i, is_cache_i, not_exc_i;
    exc_code_t exc_code_i, exc_code_o;
    cache_op_t cache_op_i, icache_op_o, dcache_op_o;
    logic [1:0] src_is_reg_i;
    fwd_sel_t [1:0] fwd_sel_i;
    word_t [1:0] imm_src_i, id_data_i;
    alu_op_e alu_op_i;
    logic prev_valid_i, next_allowin_i, reexe_ok_i, flush_i, wb_has_risk_i;
    logic icache_ok_i, dcache_ok_i, icache_req_o, dcache_req_o;
    word_t icache_addr_o, dcache_addr_o, final_res_o, except_pc_o, bad_vaddr_o;
    logic allowin_o, valid_o, has_exception_o, is_interrupt_o, is_delay_slot_o, cache_flush_o;

    word_t    stim [0:1023];
    int       num_tests = 0;
    int       err_count = 0;
    logic [31:0] lfsr = 32'h0b448faf;
    gpr_idx_t exp_num_q [$];     // write_num of every instruction that must retire

    mem_stage_top #(.NUM_IRQ(8)) i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_exc(input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: exc_code got %h expected %h", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_cache(input logic [1:0] got_tgt, input cache_op_t got_op,
                               input logic [1:0] exp_tgt, input cache_op_t exp_op);
        if (got_tgt !== exp_tgt || got_op !== exp_op) begin
            $display("Mismatch at %0t: cache target %0d op %h expected target %0d op %h",
                     $time, got_tgt, got_op, exp_tgt, exp_op);
            err_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one instruction from entry to retire or flush
    task automatic run_test(input int t);
        word_t       c [NCOL];
        logic [31:0] r;
        logic        entered;
        logic        finished;
        logic [1:0]  exp_tgt;
        logic [1:0]  got_tgt;
        logic [7:0]  exp_exc;
        word_t       exp_vaddr;
        logic        exp_ds;
        int          cycles;
        int          ok_wait;
        int          done_cnt;
        int          errs_before;
        errs_before = err_count;
        for (int k = 0; k < NCOL; k++) c[k] = stim[1 + t * NCOL + k];
        exp_tgt = c[23][1:0];
        exp_exc = c[22][7:0];
        exp_vaddr = 32'h2000_0000 + 32'(t) * 32'h10;
        exp_ds    = t[0];
        @(negedge clk);
        alu_op_i     = alu_op_e'(c[0][3:0]);
        src_is_reg_i = c[1][1:0];
        fwd_sel_i[0] = c[2][2:0];
        fwd_sel_i[1] = c[3][2:0];
        not_exc_i    = c[4][0];
        read_cp0_i   = c[5][0];
        is_cache_i   = c[6][0];
        cache_op_i   = c[7][4:0];
        has_exc_i    = c[8][0];
        exc_code_i   = c[9][4:0];
        imm_src_i    = {c[12], c[11]};
        id_data_i    = {c[14], c[13]};
        reexe_data_i = c[15];
        wb_fwd_i     = c[16];
        pre_res_i    = c[17];
        cp0_rdata_i  = c[18];
        cause_i      = c[19];
        status_i     = c[20];
        pc_i         = 32'h1000 + 4 * t;
        bad_vaddr_i  = exp_vaddr;
        is_delay_slot_i = exp_ds;
        write_num_i  = gpr_idx_t'(t);
        prev_valid_i = 1'b1;
        entered = 1'b0;
        while (!entered) begin
            rand_bits(2, r);
            next_allowin_i = |r[1:0];
            @(posedge clk);
            entered = allowin_o;
            @(negedge clk);
        end
        prev_valid_i = 1'b0;
        if (c[10][0]) begin
            flush_i = 1'b1;     // flushed in its first cycle and never retires
            @(posedge clk);
            check_bit("valid_o in flush", valid_o, 1'b0);
            @(negedge clk);
            flush_i = 1'b0;
        end else begin
            exp_num_q.push_back(gpr_idx_t'(t));
            rand_bits(2, r);
            ok_wait  = int'(r);
            cycles   = 0;
            done_cnt = 0;
            finished = 1'b0;
            while (!finished) begin
                if (cycles > 0) begin
                    rand_bits(32, r);
                    wb_fwd_i = r;   // frozen copy must hide this
                end
                if (exp_tgt != 2'd2 && cycles >= ok_wait) begin
                    icache_ok_i    = exp_tgt == 2'd0;
                    dcache_ok_i    = exp_tgt == 2'd1;
                    next_allowin_i = 1'b1;
                end else if (cycles == 0 && (c[2][FWD_WB] || c[3][FWD_WB])) begin
                    next_allowin_i = 1'b0;  // held while write-back moves on
                end else begin
                    rand_bits(2, r);
                    next_allowin_i = |r[1:0];
                end
                @(posedge clk);
                got_tgt = icache_req_o ? (dcache_req_o ? 2'd3 : 2'd0)
                                       : (dcache_req_o ? 2'd1 : 2'd2);
                check_cache(got_tgt, dcache_req_o ? dcache_op_o : icache_op_o,
                            exp_tgt, c[7][4:0]);
                if (exp_tgt != 2'd2) begin
                    check_word("cache addr", dcache_req_o ? dcache_addr_o : icache_addr_o,
                               c[17]);
                end
                if (cache_flush_o) done_cnt++;
                if (valid_o) begin
                    finished = 1'b1;
                    check_word("final_res", final_res_o, c[21]);
                    check_bit("cache_flush_o", cache_flush_o, exp_tgt != 2'd2);
                    check_bit("has_exception_o", has_exception_o, exp_exc != 8'hff);
                    check_word("bad_vaddr", bad_vaddr_o, exp_vaddr);
                    check_bit("is_delay_slot_o", is_delay_slot_o, exp_ds);
                    if (exp_exc != 8'hff) begin
                        check_exc(exc_code_o, exp_exc[4:0]);
                        check_bit("is_interrupt_o", is_interrupt_o, exp_exc == 8'h00);
                        check_word("except_pc", except_pc_o, 32'h1000 + 4 * t);
                    end
                end
                cycles++;
                @(negedge clk);
            end
            icache_ok_i = 1'b0;
            dcache_ok_i = 1'b0;
            if (done_cnt != ((exp_tgt != 2'd2) ? 1 : 0)) begin
                $display("Cache completed %0d times for test %0d", done_cnt, t);
                err_count++;
            end
        end
        $display("test %0d: %s", t, (err_count == errs_before) ? "ok" : "failed");
    endtask

    // retire order and uniqueness
    always @(posedge clk) begin
        if (arst_n_i && valid_o) begin
            if (exp_num_q.size() == 0) begin
                $display("An instruction retired that was never expected at %0t", $time);
                err_count++;
            end else begin
                check_word("retired write_num", 32'(write_num_o), 32'(exp_num_q.pop_front()));
            end
        end
    end

    // watchdog
    initial begin
        wait (num_tests != 0);
        #((num_tests + 2) * 40 * CLK_PERIOD);
        $display("Simulation timed out before all tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n_i = 1'b0;
        {write_num_i, pc_i, is_delay_slot_i, pre_res_i, has_exc_i, exc_code_i} = '0;
        {bad_vaddr_i, read_cp0_i, is_cache_i, cache_op_i, not_exc_i, src_is_reg_i} = '0;
        fwd_sel_i = '0;
        imm_src_i = '0;
        id_data_i = '0;
        reexe_data_i = '0;
        alu_op_i = ALU_ADD;
        {prev_valid_i, next_allowin_i, flush_i, wb_has_risk_i} = '0;
        reexe_ok_i = 1'b1;
        {cause_i, status_i, cp0_rdata_i, wb_fwd_i} = '0;
        icache_ok_i = 1'b0;
        dcache_ok_i = 1'b0;
        $readmemh("test/mem_stimulus.txt", stim);
        num_tests = int'(stim[0]);
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        for (int t = 0; t < num_tests; t++) run_test(t);
        repeat (2) @(negedge clk);
        if (exp_num_q.size() != 0) begin
            $display("%0d instructions never retired", exp_num_q.size());
            err_count++;
        end
        $display("tests run %0d, errors %0d", num_tests, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/mem_stimulus.txt ====
// first word is the instruction count, then 24 hex columns per instruction:
// alu src fs0 fs1 not_exc read_cp0 is_cache cache_op has_exc exc_code flush imm0 imm1
// id0 id1 reexe wb pre_res cp0_rdata cause status exp_res exp_exc(ff none) exp_tgt(2 none)
15
0 3 1 1 1 0 0 0 0 0 0 0 0 5 7 0 0 0 0 0 0 c ff 2
1 3 2 1 1 0 0 0 0 0 0 0 0 ffffffff 3 10 0 0 0 0 0 d ff 2
2 3 4 1 1 0 0 0 0 0 0 0 0 0 0f0f0f0f 0 12345678 0 0 0 0 02040608 ff 2
3 1 1 0 1 0 0 0 0 0 0 0 abcd f0000000 0 0 0 0 0 0 0 f000abcd ff 2
4 0 0 0 1 0 0 0 0 0 0 ffff0000 00ffff00 0 0 0 0 0 0 0 0 ff00ff00 ff 2
5 3 4 4 1 0 0 0 0 0 0 0 0 0 0 0 f0f 0 0 0 0 fffff0f0 ff 2
6 1 1 0 1 0 0 0 0 0 0 0 123 4 0 0 0 0 0 0 0 1230 ff 2
7 3 2 1 1 0 0 0 0 0 0 0 0 0 80000000 8 0 0 0 0 0 00800000 ff 2
8 3 1 4 1 0 0 0 0 0 0 0 0 4 0 0 80000000 0 0 0 0 f8000000 ff 2
9 3 1 1 1 0 0 0 0 0 0 0 0 ffffffff 1 0 0 0 0 0 0 1 ff 2
a 3 1 1 1 0 0 0 0 0 0 0 0 ffffffff 1 0 0 0 0 0 0 0 ff 2
0 3 0 1 1 0 0 0 0 0 0 0 0 77 42 0 0 0 0 0 0 42 ff 2
0 3 1 1 1 1 0 0 0 0 0 0 0 1 2 0 0 0 deadbeef 0 0 deadbeef ff 2
0 3 1 1 0 0 0 0 0 0 0 0 0 1 2 0 0 cafef00d 0 0 0 cafef00d ff 2
0 0 0 0 0 0 1 8 0 0 0 0 0 0 0 0 0 400000 0 0 0 400000 ff 0
0 0 0 0 0 0 1 15 0 0 0 0 0 0 0 0 0 80001000 0 0 0 80001000 ff 1
0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 11111111 0 400 401 11111111 0 2
0 0 0 0 0 0 0 0 1 c 0 0 0 0 0 0 0 22222222 0 400 1 22222222 c 2
0 0 0 0 0 0 0 0 1 4 0 0 0 0 0 0 0 33333333 0 400 403 33333333 4 2
0 0 0 0 1 0 0 0 0 0 1 1 1 0 0 0 0 0 0 0 0 2 ff 2
0 0 0 0 1 0 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 3 ff 2

// ==== tb.f ====
logic/mem_pkg.sv
logic/stage_bus_if.sv
logic/stage_latch.sv
logic/delayed_exec.sv
logic/cache_dispatch.sv
logic/stage_commit.sv
logic/mem_stage_top.sv
test/mem_stage_assertions.sv
test/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mem_stage \
    -o tb_mem_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1
